/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module scale_tb -o scale_sim

status=0
output=$(./obj_dir/scale_sim 2>&1) || status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  exit "$status"
fi
grep -q "Test completed successfully" <<< "$output"

/* tb.f */
verilog/scale_pkg.sv
verilog/delay_valid.sv
verilog/scale_mult_pipe.sv
verilog/scale_csr.sv
verilog/scale_top.sv
test/scale_sva.sv
test/scale_tb.sv

/* test/scale_sva.sv */
`default_nettype none

// Latency and response-hold checks for the scaler, bound into scale_top
module scale_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  in_valid,
  input scale_pkg::scale_cfg_t cfg,
  input logic                  out_valid,
  input logic                  bvalid,
  input logic                  bready,
  input logic                  rvalid,
  input logic                  rready
);
  import scale_pkg::*;

  // A sample enters the pipeline only while the block is enabled
  logic accept;

  assign accept = in_valid & cfg.enable;

  // Every accepted sample leaves exactly PIPE_STAGES cycles later
  latency_exact: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> ##PIPE_STAGES out_valid)
    else $error("accepted sample did not appear after the pipeline latency");

  // No result without a matching accepted sample
  no_spurious_out: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(accept, PIPE_STAGES))
    else $error("out_valid without an accepted sample before it");

  // --------------------------------------------------
  // AXI4-Lite responses hold until taken
  // --------------------------------------------------

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

endmodule

bind scale_top scale_sva scale_sva_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .cfg       (cfg),
  .out_valid (out_valid),
  .bvalid    (bvalid),
  .bready    (bready),
  .rvalid    (rvalid),
  .rready    (rready)
);

`default_nettype wire

/* test/scale_tb.sv */
`default_nettype none

module scale_tb;
  import scale_pkg::*;

  localparam int RAND_ROUNDS   = 3;
  localparam int RAND_SAMPLES  = 100;
  localparam int B2B_SAMPLES   = 64;
  localparam int GATED_SAMPLES = 32;
  // Stream cycles with gaps, plus a margin for all the register traffic
  localparam int TEST_CYCLES   = 2 * RAND_ROUNDS * RAND_SAMPLES + B2B_SAMPLES
                                 + GATED_SAMPLES + 300;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  sample_t     in_sample;
  logic        out_valid;
  result_t     out_result;
  logic        awvalid;
  logic        awready;
  axil_addr_t  awaddr;
  logic        wvalid;
  logic        wready;
  axil_wdata_t wdata;
  logic        bvalid;
  logic        bready;
  axil_resp_e  bresp;
  logic        arvalid;
  logic        arready;
  axil_addr_t  araddr;
  logic        rvalid;
  logic        rready;
  axil_rdata_t rdata;

  // Shadow copy of the configuration, kept by the register writes
  logic                enable_sh;
  logic signed [15:0]  gain_sh;
  logic signed [31:0]  offset_sh;
  logic [31:0]         rng;
  int                  cyc_cnt;
  int                  outs_seen;
  // Expected results in order, with the cycle each sample went in
  result_t             exp_q[$];
  int                  cyc_q[$];

  scale_top scale_top_i (
    .clk (clk), .rst_n (rst_n),
    .in_valid (in_valid), .in_sample (in_sample),
    .out_valid (out_valid), .out_result (out_result),
    .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
    .wvalid (wvalid), .wready (wready), .wdata (wdata),
    .bvalid (bvalid), .bready (bready), .bresp (bresp),
    .arvalid (arvalid), .arready (arready), .araddr (araddr),
    .rvalid (rvalid), .rready (rready), .rdata (rdata)
  );

  always #4 clk = ~clk;

  // --------------------------------------------------
  // Reference model and checks
  // --------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Gain times sample plus offset, wrapping in 32-bit integer arithmetic
  function automatic logic [31:0] expected_result(input logic signed [15:0] sample,
                                                  input logic signed [15:0] gain,
                                                  input logic signed [31:0] offset);
    int s;
    int g;
    int o;
    s = sample;
    g = gain;
    o = offset;
    return s * g + o;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_result(input string name, input result_t got, input result_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e got_resp,
                            input axil_resp_e exp_resp, input logic [31:0] got_data,
                            input logic [31:0] exp_data);
    if (got_resp !== exp_resp) begin
      abort_run($sformatf("[ERROR] %0t %s resp: got %s, expected %s", $time, name,
                          got_resp.name(), exp_resp.name()));
    end
    if (got_data !== exp_data) begin
      abort_run($sformatf("[ERROR] %0t %s data: got %h, expected %h", $time, name,
                          got_data, exp_data));
    end
  endtask

  // Cycle count for latency checks, and the hard stop
  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the test did not finish within the cycle limit");
    end
  end

  // Compare process, sampling at the falling edge where everything is stable
  always @(negedge clk) begin
    result_t e;
    int lat;
    if (rst_n) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("A result came out although no sample was waiting for one");
        end
        check_result("out_result", out_result, exp_q.pop_front());
        lat = cyc_cnt - cyc_q.pop_front();
        if (lat != PIPE_STAGES) begin
          abort_run($sformatf("[ERROR] %0t latency: got %0d, expected %0d", $time, lat,
                              PIPE_STAGES));
        end
        outs_seen++;
      end
      // The sample in front of the DUT is taken at the next rising edge
      if (in_valid && enable_sh) begin
        e.value = expected_result(in_sample.data, gain_sh, offset_sh);
        e.tag   = in_sample.tag;
        exp_q.push_back(e);
        cyc_q.push_back(cyc_cnt);
      end
    end
  end

  // --------------------------------------------------
  // AXI4-Lite master tasks
  // --------------------------------------------------

  task automatic axil_write(input logic [3:0] a, input logic [31:0] d,
                            input axil_resp_e exp);
    axil_resp_e got;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= '{addr: a};
    wvalid  <= 1'b1;
    wdata   <= '{data: d, strb: 4'hf};
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    // Keep bready low for a while so the response has to wait
    repeat (2) @(negedge clk);
    if (!bvalid) begin
      abort_run("bvalid dropped while bready was held low");
    end
    got = bresp;
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    check_resp("bresp", got, exp, 32'h0, 32'h0);
    // Only bit 0 of CTRL and the low half of GAIN are kept
    if (exp == OKAY) begin
      case (csr_reg_e'(a))
        CTRL:    enable_sh = d[0];
        GAIN:    gain_sh   = d[15:0];
        OFFSET:  offset_sh = d;
        default: ;
      endcase
    end
  endtask

  task automatic axil_read(input logic [3:0] a, input logic [31:0] exp_data,
                           input axil_resp_e exp_resp);
    axil_rdata_t got;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= '{addr: a};
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    // Keep rready low for a while, the read data must stay put
    repeat (2) @(negedge clk);
    if (!rvalid) begin
      abort_run("rvalid dropped while rready was held low");
    end
    got = rdata;
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
    check_resp("rdata", got.resp, exp_resp, got.data, exp_data);
  endtask

  // --------------------------------------------------
  // Stream tasks
  // --------------------------------------------------

  // Roughly three idle cycles in eight between samples
  task automatic send_stream(input int n_samples, input logic gaps);
    int sent;
    sent = 0;
    while (sent < n_samples) begin
      rng = xorshift(rng);
      @(posedge clk);
      if (!gaps || rng[2:0] < 3'd5) begin
        in_valid  <= 1'b1;
        in_sample <= '{data: rng[31:16], tag: gaps ? rng[15:8] : sent[7:0]};
        sent++;
      end else begin
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0) @(negedge clk);
    repeat (PIPE_STAGES + 2) @(negedge clk);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_sample = '0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    enable_sh = 1'b0;
    gain_sh   = '0;
    offset_sh = '0;
    rng       = 32'h93a7955e;
    cyc_cnt   = 0;
    outs_seen = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Everything reads zero after reset
    axil_read(4'h0, 32'h0, OKAY);
    axil_read(4'h4, 32'h0, OKAY);
    axil_read(4'h8, 32'h0, OKAY);
    axil_read(4'hC, 32'h0, OKAY);

    // Read back, GAIN comes back sign-extended
    axil_write(4'h4, 32'h0000_8123, OKAY);
    axil_read(4'h4, 32'hffff_8123, OKAY);
    axil_write(4'h8, 32'hdead_beef, OKAY);
    axil_read(4'h8, 32'hdead_beef, OKAY);
    axil_write(4'h0, 32'h0000_0001, OKAY);
    axil_read(4'h0, 32'h0000_0001, OKAY);
    axil_write(4'h0, 32'hffff_fffe, OKAY);
    axil_read(4'h0, 32'h0000_0000, OKAY);

    // Unmapped offsets answer SLVERR and leave the registers alone
    axil_write(4'h6, 32'h5555_5555, SLVERR);
    axil_write(4'h1, 32'hffff_ffff, SLVERR);
    axil_read(4'hE, 32'h0, SLVERR);
    axil_read(4'h3, 32'h0, SLVERR);
    axil_read(4'h4, 32'hffff_8123, OKAY);
    axil_read(4'h8, 32'hdead_beef, OKAY);
    axil_read(4'h0, 32'h0, OKAY);

    // Random stream with gaps, a fresh gain and offset each round
    for (int r = 0; r < RAND_ROUNDS; r++) begin
      rng = xorshift(rng);
      axil_write(4'h4, rng, OKAY);
      rng = xorshift(rng);
      axil_write(4'h8, rng, OKAY);
      axil_write(4'h0, 32'h1, OKAY);
      send_stream(RAND_SAMPLES, 1'b1);
      wait_drain();
    end

    // Full throughput, one sample every cycle
    send_stream(B2B_SAMPLES, 1'b0);
    wait_drain();

    // Disabled block swallows every sample
    axil_write(4'h0, 32'h0, OKAY);
    send_stream(GATED_SAMPLES, 1'b0);
    wait_drain();

    // COUNT tracks every result, and a write clears it
    axil_read(4'hC, outs_seen, OKAY);
    axil_write(4'hC, 32'h1234_5678, OKAY);
    axil_read(4'hC, 32'h0, OKAY);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/delay_valid.sv */
`default_nettype none

// Fixed delay line for a valid bit and its payload
// Only the valid bits are reset; each payload register captures
// only when the stage feeding it holds valid data
module delay_valid #(
  parameter int width      = 1,
  parameter int num_stages = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic [width-1:0]      in,
  output logic                  out_valid,
  output logic [width-1:0]      out,
  // Bit 0 is the input valid, bit num_stages is the output valid
  output logic [num_stages:0]   out_valid_stages
);

  if (num_stages == 0) begin : gen_passthru
    // No registers at all, the output is the input
    assign out_valid        = in_valid;
    assign out              = in;
    assign out_valid_stages = in_valid;
  end else begin : gen_chain
    logic [num_stages-1:0]            valid_q;
    logic [num_stages-1:0][width-1:0] data_q;

    // Valid chain, cleared by reset so nothing spurious leaves the line
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int i = 1; i < num_stages; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    // Payload chain, each stage holds its value while idle
    always_ff @(posedge clk) begin
      if (in_valid) begin
        data_q[0] <= in;
      end
      for (int i = 1; i < num_stages; i++) begin
        if (valid_q[i-1]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    assign out_valid        = valid_q[num_stages-1];
    assign out              = data_q[num_stages-1];
    assign out_valid_stages = {valid_q, in_valid};
  end

endmodule

`default_nettype wire

/* verilog/scale_csr.sv */
`default_nettype none

// AXI4-Lite register block for the scaler
// One write and one read may be outstanding, each on its own path
module scale_csr (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   awvalid,
  output logic                   awready,
  input  scale_pkg::axil_addr_t  awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  scale_pkg::axil_wdata_t wdata,
  output logic                   bvalid,
  input  logic                   bready,
  output scale_pkg::axil_resp_e  bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  scale_pkg::axil_addr_t  araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output scale_pkg::axil_rdata_t rdata,
  input  logic                   result_fire,
  output scale_pkg::scale_cfg_t  cfg
);
  import scale_pkg::*;

  // CTRL, GAIN and OFFSET live directly in the config struct
  scale_cfg_t             cfg_q;
  logic [AXIL_DATA_W-1:0] count_q;

  // Shared ready for the address and data channels
  logic                   wr_ready_q;
  logic                   wr_fire;
  logic                   ar_fire;
  csr_reg_e               wr_reg;
  csr_reg_e               rd_reg;
  logic                   wr_hit;
  logic                   count_clr;
  axil_rdata_t            rd_word;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  // Offsets outside the map fall through to the default arms
  always_comb begin
    wr_reg = csr_reg_e'(awaddr.addr);
    case (wr_reg)
      CTRL, GAIN, OFFSET, COUNT: wr_hit = 1'b1;
      default:                   wr_hit = 1'b0;
    endcase
  end

  // Read word as returned on R, sign-extending the 16-bit gain
  always_comb begin
    rd_reg  = csr_reg_e'(araddr.addr);
    rd_word = '{data: '0, resp: OKAY};
    case (rd_reg)
      CTRL:    rd_word.data = {{(AXIL_DATA_W-1){1'b0}}, cfg_q.enable};
      GAIN:    rd_word.data = {{(AXIL_DATA_W-SAMPLE_W){cfg_q.gain[SAMPLE_W-1]}}, cfg_q.gain};
      OFFSET:  rd_word.data = cfg_q.offset;
      COUNT:   rd_word.data = count_q;
      default: rd_word.resp = SLVERR;
    endcase
  end

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------

  assign wr_fire   = wr_ready_q & awvalid & wvalid;
  assign count_clr = wr_fire & (wr_reg == COUNT);
  assign awready   = wr_ready_q;
  assign wready    = wr_ready_q;

  // Ready pulses for one cycle once both channels are offered,
  // and stays low while a write response waits for bready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready_q <= 1'b0;
      bvalid     <= 1'b0;
    end else begin
      wr_ready_q <= awvalid & wvalid & ~bvalid & ~wr_ready_q;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_hit ? OKAY : SLVERR;
    end
  end

  // Strobes are ignored and every write replaces the whole register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (wr_fire) begin
      case (wr_reg)
        CTRL:    cfg_q.enable <= wdata.data[0];
        GAIN:    cfg_q.gain   <= wdata.data[SAMPLE_W-1:0];
        OFFSET:  cfg_q.offset <= wdata.data;
        default: ;
      endcase
    end
  end

  // Result counter, a clear by software beats a coincident result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (count_clr) begin
      count_q <= '0;
    end else if (result_fire) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign cfg = cfg_q;

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------

  assign ar_fire = arvalid & arready;

  // arready drops while a read response is pending and comes
  // back the cycle after the master takes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= ~(ar_fire | (rvalid & ~rready));
      if (ar_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Data is sampled at the address handshake and held until taken
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

/* verilog/scale_mult_pipe.sv */
`default_nettype none

// Three-stage multiply-add, result = gain * sample + offset
// The tag and valid ride in a delay line beside the arithmetic
module scale_mult_pipe (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  scale_pkg::sample_t    in_sample,
  input  scale_pkg::scale_cfg_t cfg,
  output logic                  out_valid,
  output scale_pkg::result_t    out_result
);
  import scale_pkg::*;

  // A sample only enters when the block is enabled
  logic                       accept;
  // Stage valids from the delay line, bit 0 is the accepted input
  logic [PIPE_STAGES:0]       stage_valid;
  logic [TAG_W-1:0]           tag_out;

  logic signed [SAMPLE_W-1:0] s1_sample;
  logic signed [SAMPLE_W-1:0] s1_gain;
  logic signed [RESULT_W-1:0] s1_offset;
  logic signed [RESULT_W-1:0] s2_prod;
  logic signed [RESULT_W-1:0] s2_offset;
  logic signed [RESULT_W-1:0] s3_sum;

  assign accept = in_valid & cfg.enable;

  // --------------------------------------------------
  // Valid and tag alignment
  // --------------------------------------------------

  delay_valid #(
    .width      (TAG_W),
    .num_stages (PIPE_STAGES)
  ) tag_delay_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (accept),
    .in               (in_sample.tag),
    .out_valid        (out_valid),
    .out              (tag_out),
    .out_valid_stages (stage_valid)
  );

  // --------------------------------------------------
  // Arithmetic stages
  // --------------------------------------------------

  // Stage 1 captures the operands together with the configuration,
  // so later register writes cannot disturb a sample in flight
  always_ff @(posedge clk) begin
    if (stage_valid[0]) begin
      s1_sample <= in_sample.data;
      s1_gain   <= cfg.gain;
      s1_offset <= cfg.offset;
    end
  end

  // Stage 2 forms the full 32-bit signed product
  always_ff @(posedge clk) begin
    if (stage_valid[1]) begin
      s2_prod   <= s1_sample * s1_gain;
      s2_offset <= s1_offset;
    end
  end

  // Stage 3 adds the offset, any overflow simply wraps
  always_ff @(posedge clk) begin
    if (stage_valid[2]) begin
      s3_sum <= s2_prod + s2_offset;
    end
  end

  assign out_result = '{value: s3_sum, tag: tag_out};

endmodule

`default_nettype wire

/* verilog/scale_pkg.sv */
`default_nettype none

package scale_pkg;

  // --------------------------------------------------
  // Widths and latency
  // --------------------------------------------------

  // Cycles from an accepted sample to its result
  localparam int PIPE_STAGES = 3;

  localparam int SAMPLE_W = 16;
  localparam int TAG_W    = 8;
  localparam int RESULT_W = 32;

  // Register block bus widths
  localparam int AXIL_ADDR_W = 4;
  localparam int AXIL_DATA_W = 32;

  // --------------------------------------------------
  // Enums
  // --------------------------------------------------

  // AXI4-Lite response codes, only the two the slave ever returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // Register map, byte offsets on a word-aligned bus
  typedef enum logic [AXIL_ADDR_W-1:0] {
    CTRL   = 4'h0,
    GAIN   = 4'h4,
    OFFSET = 4'h8,
    COUNT  = 4'hC
  } csr_reg_e;

  // --------------------------------------------------
  // Structs
  // --------------------------------------------------

  // Stream sample with its sideband tag
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] data;
    logic        [TAG_W-1:0]    tag;
  } sample_t;

  // Stream result, the tag travels unchanged from the sample
  typedef struct packed {
    logic signed [RESULT_W-1:0] value;
    logic        [TAG_W-1:0]    tag;
  } result_t;

  // Configuration handed from the register block to the pipeline
  typedef struct packed {
    logic                       enable;
    logic signed [SAMPLE_W-1:0] gain;
    logic signed [RESULT_W-1:0] offset;
  } scale_cfg_t;

  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
  } axil_addr_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0]   data;
    logic [AXIL_DATA_W/8-1:0] strb;
  } axil_wdata_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    axil_resp_e             resp;
  } axil_rdata_t;

endpackage

`default_nettype wire

/* verilog/scale_top.sv */
`default_nettype none

// Stream scaler top, register block plus arithmetic pipeline
module scale_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Sample stream, no back-pressure in either direction
  input  logic                   in_valid,
  input  scale_pkg::sample_t     in_sample,
  output logic                   out_valid,
  output scale_pkg::result_t     out_result,
  // AXI4-Lite slave port
  input  logic                   awvalid,
  output logic                   awready,
  input  scale_pkg::axil_addr_t  awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  scale_pkg::axil_wdata_t wdata,
  output logic                   bvalid,
  input  logic                   bready,
  output scale_pkg::axil_resp_e  bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  scale_pkg::axil_addr_t  araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output scale_pkg::axil_rdata_t rdata
);

  // Enable, gain and offset from the registers to the pipeline
  scale_pkg::scale_cfg_t cfg;

  // Every result leaving the pipeline also bumps COUNT
  scale_csr scale_csr_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .awvalid     (awvalid),
    .awready     (awready),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wready      (wready),
    .wdata       (wdata),
    .bvalid      (bvalid),
    .bready      (bready),
    .bresp       (bresp),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata),
    .result_fire (out_valid),
    .cfg         (cfg)
  );

  scale_mult_pipe scale_mult_pipe_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .cfg        (cfg),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

endmodule

`default_nettype wire
